/* common/spiBusPkg.sv */
package spiBusPkg;

	// Bus widths
	localparam int adrsWidth = 32;
	localparam int dataWidth = 32;

	// Block selector lives in address bits 15:8
	localparam int selMsb = 15;
	localparam int selLsb = 8;
	localparam logic [7:0] blockSel = 8'h03;

	// ----------------------------------------------------------
	// Register offsets inside the block
	// ----------------------------------------------------------
	// Transfer enable cleared by hardware at end of byte
	localparam logic [7:0] offEn = 8'h00;
	// SCLK half period divisor
	localparam logic [7:0] offDiv = 8'h04;
	// Transmit byte
	localparam logic [7:0] offWd = 8'h08;
	// Chip select level driven active low on the pin
	localparam logic [7:0] offCs = 8'h0c;
	// Read only receive byte
	localparam logic [7:0] offRd = 8'h80;

	// ----------------------------------------------------------
	// Bus request from the outside master
	// ----------------------------------------------------------
	// Address always presented
	// Write strobe qualifies the data word
	typedef struct packed {
		logic wrEn;
		logic [adrsWidth-1:0] adrs;
		logic [dataWidth-1:0] wd;
	} csrReq;

	// ----------------------------------------------------------
	// Bus response from the register block
	// ----------------------------------------------------------
	// One cycle valid pulse per block match
	// Read word holds until the next match
	typedef struct packed {
		logic valid;
		logic [dataWidth-1:0] rd;
	} csrRsp;

endpackage

/* common/spiCorePkg.sv */
package spiCorePkg;

	// Width of the SCLK half period divisor
	localparam int divWidth = 16;

	// ----------------------------------------------------------
	// Register block to shift engine
	// ----------------------------------------------------------
	// en starts one byte exchange
	// div sets half period as div+1 system cycles
	// wd is the byte sent MSB first
	typedef struct packed {
		logic en;
		logic [divWidth-1:0] div;
		logic [7:0] wd;
	} spiCtrl;

	// ----------------------------------------------------------
	// Shift engine back to register block
	// ----------------------------------------------------------
	// done pulses once per finished byte
	// rd keeps the last received byte
	typedef struct packed {
		logic done;
		logic [7:0] rd;
	} spiResult;

	// ----------------------------------------------------------
	// SPI output pins
	// ----------------------------------------------------------
	// sclk and mosi from the shift engine
	// csN straight from the chip select register
	typedef struct packed {
		logic sclk;
		logic mosi;
		logic csN;
	} spiPins;

endpackage

/* spi/spiCsr.sv */
module spiCsr (
	input  logic iSysClk,
	input  logic rstN,
	input  spiBusPkg::csrReq req,
	output spiBusPkg::csrRsp rsp,
	output spiCorePkg::spiCtrl ctrl,
	input  spiCorePkg::spiResult result,
	output logic csN
);
	import spiBusPkg::*;
	import spiCorePkg::*;

	// Control registers
	logic enQ;
	logic [divWidth-1:0] divQ;
	logic [7:0] wdQ;
	logic csQ;
	// Receive register holds a copy of the last exchanged byte
	logic [7:0] rxQ;

	// Decode
	logic blkHit;
	logic wrHit;
	logic [7:0] off;

	// Read-back path
	logic [dataWidth-1:0] rdMux;
	logic rspValid;
	logic [dataWidth-1:0] rspRd;

	// ----------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------
	assign off = req.adrs[7:0];
	// Read side only looks at the selector byte
	assign blkHit = (req.adrs[selMsb:selLsb] == blockSel);
	// Writes need the full address with upper bits zero
	assign wrHit = req.wrEn && blkHit && (req.adrs[adrsWidth-1:selMsb+1] == '0);

	// ----------------------------------------------------------
	// Register writes
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enQ <= 1'b0;
			divQ <= '1;
			wdQ <= 8'h00;
			csQ <= 1'b1;
			rxQ <= 8'h00;
		end
		else
		begin
			// End of byte wins over a software write
			if (result.done)
				enQ <= 1'b0;
			else if (wrHit && (off == offEn))
				enQ <= req.wd[0];
			// Shifter latches these at start so changes land on the next byte
			if (wrHit && (off == offDiv))
				divQ <= req.wd[divWidth-1:0];
			if (wrHit && (off == offWd))
				wdQ <= req.wd[7:0];
			if (wrHit && (off == offCs))
				csQ <= req.wd[0];
			// Capture received byte with the done pulse
			if (result.done)
				rxQ <= result.rd;
		end
	end

	// ----------------------------------------------------------
	// Read-back
	// ----------------------------------------------------------
	// Selected register zero extended to bus width
	always_comb
	begin
		case (off)
			offEn:   rdMux = {{(dataWidth - 1){1'b0}}, enQ};
			offDiv:  rdMux = {{(dataWidth - divWidth){1'b0}}, divQ};
			offWd:   rdMux = {{(dataWidth - 8){1'b0}}, wdQ};
			offCs:   rdMux = {{(dataWidth - 1){1'b0}}, csQ};
			offRd:   rdMux = {{(dataWidth - 8){1'b0}}, rxQ};
			// Unmapped offsets inside the block
			default: rdMux = '0;
		endcase
	end

	// Valid pulse one cycle after any block match
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			rspValid <= 1'b0;
		else
			rspValid <= blkHit;
	end

	// Read word only moves on a match
	always_ff @(posedge iSysClk)
	begin
		if (blkHit)
			rspRd <= rdMux;
	end

	// ----------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------
	assign rsp = '{valid: rspValid, rd: rspRd};
	assign ctrl = '{en: enQ, div: divQ, wd: wdQ};
	// Chip select under direct software control
	assign csN = csQ;

endmodule

/* spi/spiShifter.sv */
module spiShifter (
	input  logic iSysClk,
	input  logic rstN,
	input  spiCorePkg::spiCtrl ctrl,
	input  logic miso,
	output spiCorePkg::spiResult result,
	output logic sclk,
	output logic mosi
);
	import spiCorePkg::*;

	// Engine states
	typedef enum logic {
		stIdle,
		stShift
	} shiftState;

	shiftState state;

	// Half period down counter
	logic [divWidth-1:0] halfCnt;
	// Divisor latched at start of byte
	logic [divWidth-1:0] divQ;
	// Bits completed so far
	logic [2:0] bitCnt;
	// Transmit bits leave at the top while MISO enters at the bottom
	logic [7:0] shReg;
	// Last received byte
	logic [7:0] rdQ;
	logic doneQ;

	// Per cycle events
	logic start;
	logic halfEnd;
	logic riseEdge;
	logic fallEdge;
	logic lastFall;

	// ----------------------------------------------------------
	// Event decode
	// ----------------------------------------------------------
	// Enable still reads high during the done cycle
	// so a restart is held off for that one cycle
	assign start = (state == stIdle) && ctrl.en && !doneQ;
	// Current half period ends this cycle
	assign halfEnd = (state == stShift) && (halfCnt == '0);
	// Low half ending means SCLK rises
	assign riseEdge = halfEnd && !sclk;
	assign fallEdge = halfEnd && sclk;
	// Falling edge after the eighth high half
	assign lastFall = fallEdge && (bitCnt == 3'd7);

	// ----------------------------------------------------------
	// Control state and pins
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			halfCnt <= '0;
			bitCnt <= 3'd0;
			sclk <= 1'b0;
			mosi <= 1'b0;
			doneQ <= 1'b0;
		end
		else
		begin
			doneQ <= lastFall;
			if (start)
			begin
				// Mode 0 sets up the first bit before the first rising edge
				state <= stShift;
				halfCnt <= ctrl.div;
				bitCnt <= 3'd0;
				sclk <= 1'b0;
				mosi <= ctrl.wd[7];
			end
			else if (state == stShift)
			begin
				if (halfEnd)
				begin
					halfCnt <= divQ;
					sclk <= !sclk;
				end
				else
				begin
					halfCnt <= halfCnt - 1'b1;
				end
				// Next bit goes out on the falling edge
				if (fallEdge)
				begin
					if (bitCnt == 3'd7)
					begin
						state <= stIdle;
						mosi <= 1'b0;
					end
					else
					begin
						bitCnt <= bitCnt + 3'd1;
						// Already shifted on the rising edge
						mosi <= shReg[7];
					end
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Data path
	// ----------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (start)
		begin
			divQ <= ctrl.div;
			shReg <= ctrl.wd;
		end
		else if (riseEdge)
		begin
			// Sample MISO on rising SCLK
			shReg <= {shReg[6:0], miso};
		end
		// All eight MISO bits are in by the last falling edge
		if (lastFall)
			rdQ <= shReg;
	end

	assign result = '{done: doneQ, rd: rdQ};

endmodule

/* hdl/spiMasterTop.sv */
module spiMasterTop (
	input  logic iSysClk,
	input  logic rstN,
	input  spiBusPkg::csrReq csrIn,
	output spiBusPkg::csrRsp csrOut,
	input  logic miso,
	output spiCorePkg::spiPins pins
);
	import spiCorePkg::*;

	// Register block to engine
	spiCtrl ctrl;
	// Engine back to register block
	spiResult result;

	// Pin sources
	logic sclk;
	logic mosi;
	logic csN;

	// ----------------------------------------------------------
	// Register block
	// ----------------------------------------------------------
	spiCsr csr0 (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.req     (csrIn),
		.rsp     (csrOut),
		.ctrl    (ctrl),
		.result  (result),
		.csN     (csN)
	);

	// ----------------------------------------------------------
	// Shift engine
	// ----------------------------------------------------------
	spiShifter shift0 (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.miso    (miso),
		.result  (result),
		.sclk    (sclk),
		.mosi    (mosi)
	);

	// Gather pins into one bundle
	assign pins = '{sclk: sclk, mosi: mosi, csN: csN};

endmodule

/* verif/spiShifter_props.sv */
module spiShifterProps (
	input logic iSysClk,
	input logic rstN,
	input logic idle,
	input logic sclk,
	input logic done,
	input logic [spiCorePkg::divWidth-1:0] div
);
	timeunit 1ns;
	timeprecision 100ps;
	import spiCorePkg::*;

	// Last sampled SCLK and cycles since its last change
	logic sclkQ;
	logic [divWidth:0] sinceChange;

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sclkQ <= 1'b0;
			sinceChange <= '1;
		end
		else
		begin
			sclkQ <= sclk;
			if (sclk != sclkQ)
				sinceChange <= 17'd1;
			else if (sinceChange != '1)
				sinceChange <= sinceChange + 17'd1;
		end
	end

	// ----------------------------------------------------------
	// Engine properties
	// ----------------------------------------------------------
	// Done is a single cycle pulse
	doneOnce: assert property (@(posedge iSysClk) disable iff (!rstN) done |=> !done)
		else $error("done stayed high for two cycles");

	// Clock parked low between bytes
	idleLow: assert property (@(posedge iSysClk) disable iff (!rstN) idle |-> !sclk)
		else $error("sclk high while the engine is idle");

	// A half period lasts at least div+1 cycles
	halfMin: assert property (@(posedge iSysClk) disable iff (!rstN)
		(sclk != sclkQ) |-> (sinceChange >= {1'b0, div} + 17'd1))
		else $error("sclk toggled sooner than div+1 cycles");

endmodule

bind spiShifter spiShifterProps props0 (
	.iSysClk (iSysClk),
	.rstN    (rstN),
	.idle    (state == stIdle),
	.sclk    (sclk),
	.done    (result.done),
	.div     (divQ)
);

/* verif/spiClkGen.sv */
module spiClkGen (
	output logic iSysClk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam realtime clkPeriod = 8ns;

	// Free running system clock
	initial
	begin
		iSysClk = 1'b0;
		forever #(clkPeriod / 2) iSysClk = !iSysClk;
	end

	// Eight rising edges in reset before release on a falling edge
	initial
	begin
		rstN = 1'b0;
		#(clkPeriod * 8) rstN = 1'b1;
	end

endmodule

/* verif/spiMasterTb.sv */
module spiMasterTb;
	timeunit 1ns;
	timeprecision 100ps;
	import spiBusPkg::*;
	import spiCorePkg::*;

	// 20 bytes of 16 halves at div 7 plus register traffic and margin
	localparam int cycleLimit = 20 * 16 * 8 + 600 + 500;
	localparam csrReq idleReq = '{wrEn: 1'b0, adrs: '0, wd: '0};
	localparam csrRsp fullMask = '{valid: 1'b1, rd: '1};
	// Enable bit open while a byte is in flight
	localparam csrRsp pollMask = '{valid: 1'b1, rd: 32'hFFFF_FFFE};

	logic iSysClk;
	logic rstN;
	csrReq csrIn;
	csrRsp csrOut;
	logic miso;
	spiPins pins;

	// Shadow of the register block starting from reset values
	logic shadowEn = 1'b0;
	logic [15:0] shadowDiv = 16'hFFFF;
	logic [7:0] shadowWd = 8'h00;
	logic shadowCs = 1'b1;
	logic [7:0] shadowRx = 8'h00;

	// Expected responses each tagged with its due cycle
	int dueQ[$];
	csrRsp expQ[$];
	csrRsp maskQ[$];
	int cycleCnt = 0;
	logic [15:0] lfsr = 16'd38398;

	// Slave model and SCLK monitor
	logic [7:0] slaveSh = 8'h00;
	logic [7:0] slaveRx = 8'h00;
	logic sclkLast = 1'b0;
	logic haveLast = 1'b0;
	int lastChange = 0;
	int riseCnt = 0;
	int curDiv = 0;

	spiClkGen clkGen0 (.iSysClk(iSysClk), .rstN(rstN));

	spiMasterTop dut0 (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.csrIn   (csrIn),
		.csrOut  (csrOut),
		.miso    (miso),
		.pins    (pins)
	);

	// ----------------------------------------------------------
	// Reference model and random source
	// ----------------------------------------------------------
	// Expected read word per offset zero extended
	function automatic logic [31:0] refWord(input logic [7:0] off);
		case (off)
			offEn:   return {31'h0, shadowEn};
			offDiv:  return {16'h0, shadowDiv};
			offWd:   return {24'h0, shadowWd};
			offCs:   return {31'h0, shadowCs};
			offRd:   return {24'h0, shadowRx};
			default: return 32'h0;
		endcase
	endfunction

	// Register effect of one write truncated to width
	function automatic void shadowWrite(input logic [7:0] off, input logic [31:0] data);
		case (off)
			offEn:   shadowEn = data[0];
			offDiv:  shadowDiv = data[15:0];
			offWd:   shadowWd = data[7:0];
			offCs:   shadowCs = data[0];
			default: ;
		endcase
	endfunction

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic randBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkRsp(input string name, input csrRsp exp, input csrRsp act,
		input csrRsp mask);
		if ((act & mask) !== (exp & mask))
			failRun($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
				$time, name, exp & mask, act & mask));
	endtask

	task automatic checkPins(input string name, input spiPins exp, input spiPins act);
		if (act !== exp)
			failRun($sformatf("FAIL time=%0t signal=%s expected=%b actual=%b",
				$time, name, exp, act));
	endtask

	task automatic checkValue(input string name, input int exp, input int act);
		if (act != exp)
			failRun($sformatf("FAIL time=%0t signal=%s expected=%0d actual=%0d",
				$time, name, exp, act));
	endtask

	// ----------------------------------------------------------
	// Bus access
	// ----------------------------------------------------------
	// Response lands one cycle after the address
	task automatic expectRead(input logic [7:0] off, input csrRsp mask);
		dueQ.push_back(cycleCnt + 1);
		expQ.push_back('{valid: 1'b1, rd: refWord(off)});
		maskQ.push_back(mask);
	endtask

	task automatic writeReg(input logic [7:0] off, input logic [31:0] data, input logic wr);
		@(negedge iSysClk);
		csrIn = '{wrEn: wr, adrs: {16'h0, blockSel, off}, wd: data};
		// Block match reads back the value before the write
		expectRead(off, fullMask);
		if (wr)
			shadowWrite(off, data);
		@(negedge iSysClk);
		csrIn = idleReq;
	endtask

	task automatic readReg(input logic [7:0] off, input csrRsp mask,
		output logic [31:0] data);
		@(negedge iSysClk);
		csrIn = '{wrEn: 1'b0, adrs: {16'h0, blockSel, off}, wd: '0};
		expectRead(off, mask);
		@(negedge iSysClk);
		csrIn = idleReq;
		data = csrOut.rd;
	endtask

	task automatic writeAndCheck(input logic [7:0] off, input logic wr);
		logic [31:0] word;
		randBits(32, word);
		writeReg(off, word, wr);
		readReg(off, fullMask, word);
	endtask

	// One byte exchange polled until enable drops
	task automatic runTransfer(input logic [7:0] txByte, input logic [7:0] rxByte,
		input logic [2:0] div);
		logic [31:0] word;
		writeReg(offDiv, {29'h0, div}, 1'b1);
		writeReg(offWd, {24'h0, txByte}, 1'b1);
		// First MISO bit ahead of the first rising edge
		slaveSh = rxByte;
		slaveRx = 8'h00;
		miso = rxByte[7];
		haveLast = 1'b0;
		riseCnt = 0;
		curDiv = int'(div);
		writeReg(offEn, 32'h1, 1'b1);
		word = 32'h1;
		while (word[0])
			readReg(offEn, pollMask, word);
		// Hardware cleared enable and receive holds the slave byte
		shadowEn = 1'b0;
		shadowRx = rxByte;
		readReg(offRd, fullMask, word);
		checkValue("slave mosi byte", int'(txByte), int'(slaveRx));
		checkValue("sclk rising edges", 8, riseCnt);
	endtask

	// ----------------------------------------------------------
	// Response compare with slave model and timeout
	// ----------------------------------------------------------
	always @(negedge iSysClk)
	begin
		csrRsp expRsp;
		csrRsp maskRsp;
		if (dueQ.size() != 0 && dueQ[0] == cycleCnt)
		begin
			if (csrOut.valid !== 1'b1)
				failRun("No valid pulse one cycle after a read address");
			void'(dueQ.pop_front());
			expRsp = expQ.pop_front();
			maskRsp = maskQ.pop_front();
			checkRsp("csrOut", expRsp, csrOut, maskRsp);
		end
		else if (csrOut.valid === 1'b1)
			failRun("Valid pulse without a block address one cycle before");
	end

	// Mode 0 slave that also times each SCLK half
	always @(negedge iSysClk)
	begin
		if (pins.sclk !== sclkLast && pins.csN === 1'b0)
		begin
			if (pins.sclk)
			begin
				slaveRx = {slaveRx[6:0], pins.mosi};
				riseCnt++;
			end
			else
			begin
				slaveSh = {slaveSh[6:0], 1'b0};
				miso = slaveSh[7];
			end
			if (haveLast)
				checkValue("sclk half period", curDiv + 1, cycleCnt - lastChange);
			haveLast = 1'b1;
			lastChange = cycleCnt;
		end
		sclkLast = pins.sclk;
	end

	always @(posedge iSysClk)
	begin
		cycleCnt++;
		if (cycleCnt > cycleLimit)
			failRun($sformatf("Timeout, tests did not finish within %0d cycles",
				cycleLimit));
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial
	begin
		logic [31:0] word;
		logic [31:0] txByte;
		logic [31:0] rxByte;
		logic [31:0] divVal;
		csrIn = idleReq;
		miso = 1'b0;
		wait (rstN === 1'b1);
		@(negedge iSysClk);
		// Reset state
		checkPins("pins", '{sclk: 1'b0, mosi: 1'b0, csN: 1'b1}, pins);
		readReg(offEn, fullMask, word);
		readReg(offDiv, fullMask, word);
		readReg(offWd, fullMask, word);
		readReg(offCs, fullMask, word);
		readReg(offRd, fullMask, word);
		// Random writes followed by writes with the strobe low
		for (int i = 0; i < 4; i++)
		begin
			writeAndCheck(offDiv, 1'b1);
			writeAndCheck(offWd, 1'b1);
			writeAndCheck(offCs, 1'b1);
			writeAndCheck(offDiv, 1'b0);
			writeAndCheck(offWd, 1'b0);
			writeAndCheck(offCs, 1'b0);
			writeAndCheck(offEn, 1'b0);
		end
		// Hole in the map
		readReg(8'h40, fullMask, word);
		// Neighbour block gets no write and no pulse
		@(negedge iSysClk);
		csrIn = '{wrEn: 1'b1, adrs: {16'h0, blockSel + 8'h01, offCs},
			wd: {31'h0, !shadowCs}};
		@(negedge iSysClk);
		csrIn = idleReq;
		readReg(offCs, fullMask, word);
		// Chip select follows the register a cycle later
		writeReg(offCs, 32'h0, 1'b1);
		checkPins("pins", '{sclk: 1'b0, mosi: 1'b0, csN: 1'b0}, pins);
		writeReg(offCs, 32'h1, 1'b1);
		checkPins("pins", '{sclk: 1'b0, mosi: 1'b0, csN: 1'b1}, pins);
		writeReg(offCs, 32'h0, 1'b1);
		for (int i = 0; i < 20; i++)
		begin
			randBits(8, txByte);
			randBits(8, rxByte);
			randBits(3, divVal);
			runTransfer(txByte[7:0], rxByte[7:0], divVal[2:0]);
		end
		checkPins("pins", '{sclk: 1'b0, mosi: 1'b0, csN: 1'b0}, pins);
		@(negedge iSysClk);
		if (dueQ.size() != 0)
			failRun("Some reads never got a response");
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

/* filelist.f */
common/spiBusPkg.sv
common/spiCorePkg.sv
spi/spiCsr.sv
spi/spiShifter.sv
hdl/spiMasterTop.sv
verif/spiShifter_props.sv
verif/spiClkGen.sv
verif/spiMasterTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module spiMasterTb \
	-f filelist.f -o spiMasterSim

status=0
./obj_dir/spiMasterSim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTS PASSED" "$LOG"; then
	echo "Simulation did not complete cleanly, see $LOG"
	exit 1
fi
